// ==== hw/vrc_pkg.sv ====
package vrc_pkg;

	// mapper numbers
	localparam logic [7:0] MAP_VRC4_21  = 8'd21;
	localparam logic [7:0] MAP_VRC2_22  = 8'd22;
	localparam logic [7:0] MAP_VRC24_23 = 8'd23;
	localparam logic [7:0] MAP_VRC24_25 = 8'd25;

	// canonical register addresses after unscrambling
	localparam logic [15:0] REG_PRG0   = 16'h8000;
	localparam logic [15:0] REG_MIRROR = 16'h9000;
	localparam logic [15:0] REG_SWAP   = 16'h9002;
	localparam logic [15:0] REG_PRG1   = 16'hA000;

	// two banks per $1000 step, lo/hi part in bit 0
	localparam logic [15:0] REG_CHR_BASE = 16'hB000;

	localparam logic [15:0] REG_IRQ_LATCH_LO = 16'hF000;
	localparam logic [15:0] REG_IRQ_LATCH_HI = 16'hF001;
	localparam logic [15:0] REG_IRQ_CTRL     = 16'hF002;
	localparam logic [15:0] REG_IRQ_ACK      = 16'hF003;

	// fixed banks at the top of PRG
	localparam logic [7:0] PRG_BANK_FE = 8'hFE;
	localparam logic [7:0] PRG_BANK_FF = 8'hFF;

	// save-state slots
	localparam logic [7:0] SS_CHR_LO = 8'd0;
	localparam logic [7:0] SS_CHR_HI = 8'd8;
	localparam logic [7:0] SS_PRG0   = 8'd16;
	localparam logic [7:0] SS_PRG1   = 8'd17;
	localparam logic [7:0] SS_MODE   = 8'd18;
	localparam logic [7:0] SS_IRQ    = 8'd32;
	localparam logic [7:0] SS_MAP    = 8'd127;

	// one scanline is 341 ppu dots, three per cpu cycle
	localparam logic [8:0] PRESCALE_START = 9'd341;
	localparam logic [8:0] PRESCALE_STEP  = 9'd3;

endpackage

// ==== hw/vrc_bus_if.sv ====
`timescale 1ns/1ps

interface vrc_bus_if;

	logic [15:0] reg_addr;
	logic [7:0]  data;
	logic        we;
	logic        is_vrc2;
	logic        ss_act;
	logic        ss_we;
	logic [7:0]  ss_addr;
	logic [7:0]  ss_data;

	modport decoder (
		output reg_addr, data, we, is_vrc2,
		output ss_act, ss_we, ss_addr, ss_data
	);

	modport regs (
		input reg_addr, data, we, is_vrc2,
		input ss_act, ss_we, ss_addr, ss_data
	);

	modport irq (
		input reg_addr, data, we, is_vrc2,
		input ss_act, ss_we, ss_addr, ss_data
	);

endinterface

// ==== hw/vrc_reg_decode.sv ====
`timescale 1ns/1ps

module vrc_reg_decode (
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic [7:0]  map_idx,
	input  logic [1:0]  map_sub,
	input  logic        cfg_prg_ram_off,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	vrc_bus_if.decoder  bus
);
	import vrc_pkg::*;

	logic [1:0] sel_21;
	logic [1:0] sel_22;
	logic [1:0] sel_23;
	logic [1:0] sel_25;
	logic [1:0] sel;
	logic       latch_win;

	always_comb
	begin
		case (map_sub)
			2'd1: sel_21 = cpu_addr[2:1];
			2'd2: sel_21 = cpu_addr[7:6];
			default: sel_21 = cpu_addr[2:1] | cpu_addr[7:6]; // auto
		endcase
	end

	assign sel_22 = {cpu_addr[0], cpu_addr[1]}; // a0/a1 swapped

	always_comb
	begin
		case (map_sub)
			2'd1, 2'd3: sel_23 = cpu_addr[1:0];
			2'd2: sel_23 = cpu_addr[3:2];
			default: sel_23 = cpu_addr[1:0] | cpu_addr[3:2];
		endcase
	end

	always_comb
	begin
		case (map_sub)
			2'd1, 2'd3: sel_25 = {cpu_addr[0], cpu_addr[1]};
			2'd2: sel_25 = {cpu_addr[2], cpu_addr[3]};
			default: sel_25 = {cpu_addr[0] | cpu_addr[2], cpu_addr[1] | cpu_addr[3]};
		endcase
	end

	always_comb
	begin
		case (map_idx)
			MAP_VRC4_21: sel = sel_21;
			MAP_VRC2_22: sel = sel_22;
			MAP_VRC24_25: sel = sel_25;
			default: sel = sel_23;
		endcase
	end

	// $6000 only counts as a register when prg ram is off
	assign latch_win = cpu_addr[15:12] == 4'h6 && cfg_prg_ram_off;

	assign bus.reg_addr = {cpu_addr[15:12], 10'd0, sel};
	assign bus.data     = cpu_dat;
	assign bus.we       = !cpu_rw && (cpu_addr[15] || latch_win);
	assign bus.is_vrc2  = map_idx == MAP_VRC2_22 ||
		(map_sub == 2'd3 && (map_idx == MAP_VRC24_23 || map_idx == MAP_VRC24_25));

	assign bus.ss_act  = ss_act;
	assign bus.ss_we   = ss_we;
	assign bus.ss_addr = ss_addr;
	assign bus.ss_data = cpu_dat; // save-state data rides on the cpu data bus

endmodule

// ==== hw/vrc_bank_regs.sv ====
`timescale 1ns/1ps

module vrc_bank_regs (
	input  logic             m2,
	input  logic             map_rst,
	vrc_bus_if.regs          bus,
	input  logic [15:0]      cpu_addr,
	input  logic             cfg_prg_ram_off,
	output logic [7:0]       prg0,
	output logic [7:0]       prg1,
	output logic             swap,
	output logic [1:0]       mirror,
	output logic [7:0][8:0]  chr_banks,
	output logic             latch_oe,
	output logic [7:0]       latch_dout,
	output logic [7:0]       ss_rdat
);
	import vrc_pkg::*;

	logic       latch;
	logic       latch_ce;
	logic       wr;
	logic [3:0] chr_step;
	logic       chr_hit;
	logic [2:0] chr_idx;

	assign wr = bus.we && !bus.ss_act;

	assign latch_ce   = cpu_addr[15:12] == 4'h6 && cfg_prg_ram_off && bus.is_vrc2;
	assign latch_oe   = latch_ce && !bus.we;
	assign latch_dout = {cpu_addr[15:9], latch}; // open bus bits around the latch

	assign chr_step = bus.reg_addr[15:12] - REG_CHR_BASE[15:12];
	assign chr_hit  = bus.reg_addr[15:12] >= REG_CHR_BASE[15:12] &&
		bus.reg_addr[15:12] <= REG_IRQ_CTRL[15:12] - 4'd1;
	assign chr_idx  = {chr_step[1:0], bus.reg_addr[1]};

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			prg0   <= 8'd0;
			prg1   <= 8'd1;
			swap   <= 1'b0;
			mirror <= 2'd3;
			latch  <= 1'b0;
		end
		else if (bus.ss_act)
		begin
			if (bus.ss_we && bus.ss_addr == SS_PRG0) prg0 <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr == SS_PRG1) prg1 <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr == SS_MODE) {latch, swap, mirror} <= bus.ss_data[3:0];
		end
		else if (wr)
		begin
			if (bus.reg_addr == REG_MIRROR || cpu_addr == 16'h9FFF)
				mirror <= bus.data[1:0]; // some carts write mirroring at $9fff
			if (bus.reg_addr == REG_SWAP)
				swap <= bus.data[1] && !bus.is_vrc2; // vrc4 only
			if (bus.reg_addr[15:12] == REG_PRG0[15:12]) prg0 <= bus.data;
			if (bus.reg_addr[15:12] == REG_PRG1[15:12]) prg1 <= bus.data;
			if (latch_ce) latch <= bus.data[0];
		end
	end

	always_ff @(posedge m2)
	begin
		if (bus.ss_act)
		begin
			if (bus.ss_we && bus.ss_addr[7:3] == SS_CHR_LO[7:3])
				chr_banks[bus.ss_addr[2:0]][7:0] <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr[7:3] == SS_CHR_HI[7:3])
				chr_banks[bus.ss_addr[2:0]][8] <= bus.ss_data[0];
		end
		else if (wr && chr_hit)
		begin
			if (!bus.reg_addr[0])
				chr_banks[chr_idx][3:0] <= bus.data[3:0]; // low nibble
			else
				chr_banks[chr_idx][8:4] <= bus.data[4:0]; // high part
		end
	end

	always_comb
	begin
		if (bus.ss_addr[7:3] == SS_CHR_LO[7:3])
			ss_rdat = chr_banks[bus.ss_addr[2:0]][7:0];
		else if (bus.ss_addr[7:3] == SS_CHR_HI[7:3])
			ss_rdat = {7'd0, chr_banks[bus.ss_addr[2:0]][8]};
		else if (bus.ss_addr == SS_PRG0)
			ss_rdat = prg0;
		else if (bus.ss_addr == SS_PRG1)
			ss_rdat = prg1;
		else if (bus.ss_addr == SS_MODE)
			ss_rdat = {4'd0, latch, swap, mirror};
		else if (bus.ss_addr[7:3] == SS_IRQ[7:3] || bus.ss_addr == SS_MAP)
			ss_rdat = 8'h00; // answered by irq block or top
		else
			ss_rdat = 8'hFF;
	end

endmodule

// ==== hw/vrc_irq.sv ====
`timescale 1ns/1ps

module vrc_irq (
	input  logic       m2,
	input  logic       map_rst,
	vrc_bus_if.irq     bus,
	output logic       irq,
	output logic [7:0] ss_rdat
);
	import vrc_pkg::*;

	logic [7:0] irq_latch;
	logic [7:0] cnt;
	logic [8:0] pre;
	logic       ack_en;
	logic       irq_en;
	logic       cyc_mode;
	logic       pending;
	logic       wr;
	logic       ctrl_wr;
	logic       ack_wr;
	logic       pre_wrap;
	logic       cnt_tick;
	logic       cnt_full;

	assign wr       = bus.we && !bus.ss_act;
	assign ctrl_wr  = wr && bus.reg_addr == REG_IRQ_CTRL;
	assign ack_wr   = wr && bus.reg_addr == REG_IRQ_ACK;
	assign pre_wrap = pre <= PRESCALE_STEP;
	assign cnt_tick = irq_en && (cyc_mode || pre_wrap);
	assign cnt_full = cnt == 8'hFF;

	// latch, counter and prescaler
	always_ff @(posedge m2)
	begin
		if (bus.ss_act)
		begin
			if (bus.ss_we && bus.ss_addr == SS_IRQ) irq_latch <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr == SS_IRQ + 8'd2) cnt <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr == SS_IRQ + 8'd3) pre[7:0] <= bus.ss_data;
			if (bus.ss_we && bus.ss_addr == SS_IRQ + 8'd4) pre[8] <= bus.ss_data[0];
		end
		else
		begin
			if (wr && bus.reg_addr == REG_IRQ_LATCH_LO) irq_latch[3:0] <= bus.data[3:0];
			if (wr && bus.reg_addr == REG_IRQ_LATCH_HI) irq_latch[7:4] <= bus.data[3:0];
			if (ctrl_wr)
			begin
				cnt <= irq_latch;
				pre <= PRESCALE_START;
			end
			else if (irq_en)
			begin
				if (pre_wrap)
					pre <= pre + PRESCALE_START - PRESCALE_STEP;
				else
					pre <= pre - PRESCALE_STEP;
				if (cnt_tick)
					cnt <= cnt_full ? irq_latch : cnt + 8'd1; // reload on overflow
			end
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			ack_en   <= 1'b0;
			irq_en   <= 1'b0;
			cyc_mode <= 1'b0;
			pending  <= 1'b0;
		end
		else if (bus.ss_act)
		begin
			if (bus.ss_we && bus.ss_addr == SS_IRQ + 8'd1)
				{cyc_mode, irq_en, ack_en} <= bus.ss_data[2:0];
			if (bus.ss_we && bus.ss_addr == SS_IRQ + 8'd4)
				pending <= bus.ss_data[7];
		end
		else if (ctrl_wr)
		begin
			{cyc_mode, irq_en, ack_en} <= bus.data[2:0];
			pending <= 1'b0;
		end
		else
		begin
			if (ack_wr)
			begin
				pending <= 1'b0;
				irq_en  <= ack_en; // A bit restores E
			end
			else if (cnt_tick && cnt_full)
				pending <= 1'b1;
		end
	end

	assign irq = pending && !bus.is_vrc2; // vrc2 has no irq

	always_comb
	begin
		case (bus.ss_addr)
			SS_IRQ: ss_rdat = irq_latch;
			SS_IRQ + 8'd1: ss_rdat = {5'd0, cyc_mode, irq_en, ack_en};
			SS_IRQ + 8'd2: ss_rdat = cnt;
			SS_IRQ + 8'd3: ss_rdat = pre[7:0];
			SS_IRQ + 8'd4: ss_rdat = {pending, 6'd0, pre[8]};
			default: ss_rdat = 8'h00;
		endcase
	end

endmodule

// ==== hw/vrc_addr_map.sv ====
`timescale 1ns/1ps

module vrc_addr_map (
	input  logic [15:0]     cpu_addr,
	input  logic [13:0]     ppu_addr,
	input  logic            is_vrc2,
	input  logic [7:0]      map_idx,
	input  logic [7:0]      prg0,
	input  logic [7:0]      prg1,
	input  logic            swap,
	input  logic [1:0]      mirror,
	input  logic [7:0][8:0] chr_banks,
	output logic [20:0]     prg_addr,
	output logic [17:0]     chr_addr,
	output logic            ciram_a10,
	output logic            ciram_ce,
	output logic            rom_ce,
	output logic            ram_ce
);
	import vrc_pkg::*;

	logic [7:0] prg_bank;
	logic [8:0] chr_bank;

	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0: prg_bank = swap ? PRG_BANK_FE : prg0;
			2'd1: prg_bank = prg1;
			2'd2: prg_bank = swap ? prg0 : PRG_BANK_FE;
			default: prg_bank = PRG_BANK_FF;
		endcase
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};

	assign chr_bank = chr_banks[ppu_addr[12:10]];
	assign chr_addr[9:0]   = ppu_addr[9:0];
	assign chr_addr[17:10] = map_idx == MAP_VRC2_22 ? chr_bank[8:1] : chr_bank[7:0]; // 22 ignores bit 0

	// single screen only on vrc4, otherwise vertical/horizontal
	assign ciram_a10 = mirror[1] && !is_vrc2 ? mirror[0] :
		mirror[0] ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = !ppu_addr[13];

	assign rom_ce = cpu_addr[15];
	assign ram_ce = cpu_addr[15:13] == 3'b011;

endmodule

// ==== hw/vrc_mapper_top.sv ====
`timescale 1ns/1ps

module vrc_mapper_top (
	input  logic        m2,
	input  logic        map_rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic [13:0] ppu_addr,
	input  logic [7:0]  map_idx,
	input  logic [1:0]  map_sub,
	input  logic        cfg_prg_ram_off,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic [20:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic        ciram_a10,
	output logic        ciram_ce,
	output logic        rom_ce,
	output logic        ram_ce,
	output logic        map_cpu_oe,
	output logic [7:0]  map_cpu_dout,
	output logic [7:0]  ss_rdat,
	output logic        irq
);
	import vrc_pkg::*;

	logic [7:0]      prg0;
	logic [7:0]      prg1;
	logic            swap;
	logic [1:0]      mirror;
	logic [7:0][8:0] chr_banks;
	logic [7:0]      regs_ss;
	logic [7:0]      irq_ss;

	vrc_bus_if bus ();

	vrc_reg_decode u_decode (
		.cpu_addr        (cpu_addr),
		.cpu_dat         (cpu_dat),
		.cpu_rw          (cpu_rw),
		.map_idx         (map_idx),
		.map_sub         (map_sub),
		.cfg_prg_ram_off (cfg_prg_ram_off),
		.ss_act          (ss_act),
		.ss_we           (ss_we),
		.ss_addr         (ss_addr),
		.bus             (bus.decoder)
	);

	vrc_bank_regs u_regs (
		.m2              (m2),
		.map_rst         (map_rst),
		.bus             (bus.regs),
		.cpu_addr        (cpu_addr),
		.cfg_prg_ram_off (cfg_prg_ram_off),
		.prg0            (prg0),
		.prg1            (prg1),
		.swap            (swap),
		.mirror          (mirror),
		.chr_banks       (chr_banks),
		.latch_oe        (map_cpu_oe),
		.latch_dout      (map_cpu_dout),
		.ss_rdat         (regs_ss)
	);

	vrc_irq u_irq (
		.m2      (m2),
		.map_rst (map_rst),
		.bus     (bus.irq),
		.irq     (irq),
		.ss_rdat (irq_ss)
	);

	vrc_addr_map u_map (
		.cpu_addr  (cpu_addr),
		.ppu_addr  (ppu_addr),
		.is_vrc2   (bus.is_vrc2),
		.map_idx   (map_idx),
		.prg0      (prg0),
		.prg1      (prg1),
		.swap      (swap),
		.mirror    (mirror),
		.chr_banks (chr_banks),
		.prg_addr  (prg_addr),
		.chr_addr  (chr_addr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.rom_ce    (rom_ce),
		.ram_ce    (ram_ce)
	);

	// blocks return 0 outside their own slots
	assign ss_rdat = regs_ss | irq_ss | (ss_addr == SS_MAP ? map_idx : 8'h00);

endmodule

// ==== testbench/vrc_mapper_chk.sv ====
`timescale 1ns/1ps

module vrc_mapper_chk (
	input logic        m2,
	input logic        map_rst,
	input logic [7:0]  map_idx,
	input logic [1:0]  map_sub,
	input logic [15:0] cpu_addr,
	input logic [13:0] ppu_addr,
	input logic        ciram_ce,
	input logic        rom_ce,
	input logic        irq
);
	import vrc_pkg::*;

	logic vrc2;

	// sub-variant 3 of 23 and 25 is the vrc2 board
	assign vrc2 = map_idx == MAP_VRC2_22 ||
		(map_sub == 2'd3 && (map_idx == MAP_VRC24_23 || map_idx == MAP_VRC24_25));

	irq_vrc2_low: assert property (@(posedge m2) disable iff (map_rst) vrc2 |-> !irq)
		else $error("irq is high on a vrc2 board");

	ciram_ce_decode: assert property (@(posedge m2) ciram_ce == !ppu_addr[13])
		else $error("ciram_ce does not follow ppu_addr[13]");

	rom_ce_decode: assert property (@(posedge m2) rom_ce == cpu_addr[15])
		else $error("rom_ce does not follow cpu_addr[15]");

endmodule

// ==== testbench/vrc_mapper_tb.sv ====
`timescale 1ns/1ps

module vrc_mapper_tb;
	import vrc_pkg::*;

	localparam int TEST_CYCLES = 1600; // all tests together, the irq runs dominate
	localparam int CYCLE_LIMIT = 3 * TEST_CYCLES + 200;

	logic        m2;
	logic        map_rst;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dat;
	logic        cpu_rw;
	logic [13:0] ppu_addr;
	logic [7:0]  map_idx;
	logic [1:0]  map_sub;
	logic        cfg_prg_ram_off;
	logic        ss_act;
	logic        ss_we;
	logic [7:0]  ss_addr;
	logic [20:0] prg_addr;
	logic [17:0] chr_addr;
	logic        ciram_a10;
	logic        ciram_ce;
	logic        rom_ce;
	logic        ram_ce;
	logic        map_cpu_oe;
	logic [7:0]  map_cpu_dout;
	logic [7:0]  ss_rdat;
	logic        irq;

	int seed;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int cycles = 0;

	vrc_mapper_top dut (
		.m2 (m2), .map_rst (map_rst), .cpu_addr (cpu_addr), .cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw), .ppu_addr (ppu_addr), .map_idx (map_idx), .map_sub (map_sub),
		.cfg_prg_ram_off (cfg_prg_ram_off), .ss_act (ss_act), .ss_we (ss_we),
		.ss_addr (ss_addr), .prg_addr (prg_addr), .chr_addr (chr_addr),
		.ciram_a10 (ciram_a10), .ciram_ce (ciram_ce), .rom_ce (rom_ce), .ram_ce (ram_ce),
		.map_cpu_oe (map_cpu_oe), .map_cpu_dout (map_cpu_dout), .ss_rdat (ss_rdat),
		.irq (irq)
	);

	bind vrc_mapper_top vrc_mapper_chk u_chk (
		.m2 (m2), .map_rst (map_rst), .map_idx (map_idx), .map_sub (map_sub),
		.cpu_addr (cpu_addr), .ppu_addr (ppu_addr), .ciram_ce (ciram_ce),
		.rom_ce (rom_ce), .irq (irq)
	);

	always #10 m2 = ~m2;

	always @(posedge m2)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic byte_equal(input string sig, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s: got %h, expected %h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic word_equal(input string sig, input logic [20:0] got, input logic [20:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s: got %h, expected %h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic bit_equal(input string sig, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s: got %h, expected %h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic test_done(input string name);
		$display("%s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// cpu address that lands on canonical register {hi, sel} for a wiring
	function automatic logic [15:0] reg_cpu_addr(input logic [7:0] map, input logic [1:0] sub,
		input logic [3:0] hi, input logic [1:0] sel);
		if (map == MAP_VRC4_21)
			return sub == 2'd2 ? {hi, 4'h0, sel, 6'h0} : {hi, 9'h0, sel, 1'b0};
		else if (map == MAP_VRC2_22)
			return {hi, 10'h0, sel[0], sel[1]};
		else if (map == MAP_VRC24_25)
			return sub == 2'd2 ? {hi, 8'h0, sel[0], sel[1], 2'b0} : {hi, 10'h0, sel[0], sel[1]};
		else
			return sub == 2'd2 ? {hi, 8'h0, sel, 2'b0} : {hi, 10'h0, sel};
	endfunction

	task automatic select_variant(input logic [7:0] map, input logic [1:0] sub, input logic ram_off);
		@(negedge m2);
		map_idx = map;
		map_sub = sub;
		cfg_prg_ram_off = ram_off;
		map_rst = 1'b1;
		repeat (2) @(negedge m2);
		map_rst = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge m2);
		cpu_addr = addr;
		cpu_dat = data;
		cpu_rw = 1'b0;
		@(negedge m2);
		cpu_rw = 1'b1;
	endtask

	task automatic drive_bus(input logic [15:0] addr, input logic [13:0] paddr);
		@(negedge m2);
		cpu_addr = addr;
		ppu_addr = paddr;
		cpu_rw = 1'b1;
		#5; // settle before the next rising edge
	endtask

	task automatic reset_defaults();
		logic [7:0] exp;
		select_variant(MAP_VRC4_21, 2'd0, 1'b0);
		for (int w = 0; w < 4; w++)
		begin
			case (w)
				0: exp = 8'h00;
				1: exp = 8'h01;
				2: exp = 8'hFE;
				default: exp = 8'hFF;
			endcase
			drive_bus({1'b1, 2'(w), 13'h0123}, 14'h0);
			word_equal("prg_addr", prg_addr, {exp, 13'h0123});
			bit_equal("ram_ce", ram_ce, 1'b0);
		end
		drive_bus(16'h7123, 14'h0);
		bit_equal("ram_ce", ram_ce, 1'b1); // prg ram window
		for (int j = 0; j < 4; j++)
		begin
			drive_bus(16'h8000, {2'b10, 2'(j), 10'h0});
			bit_equal("ciram_a10", ciram_a10, 1'b1); // mode 3, screen 1
		end
		test_done("reset_defaults");
	endtask

	task automatic prg_swap_variant(input logic [7:0] map, input logic [1:0] sub,
		input logic [7:0] bank);
		logic swap_ok;
		swap_ok = map != MAP_VRC2_22;
		select_variant(map, sub, 1'b0);
		cpu_write(reg_cpu_addr(map, sub, 4'h8, 2'd0), bank);
		drive_bus(16'h8000, 14'h0);
		byte_equal("prg_addr[20:13]", prg_addr[20:13], bank);
		drive_bus(16'hC000, 14'h0);
		byte_equal("prg_addr[20:13]", prg_addr[20:13], 8'hFE);
		cpu_write(reg_cpu_addr(map, sub, 4'h9, 2'd2), 8'h02);
		drive_bus(16'h8000, 14'h0);
		byte_equal("prg_addr[20:13]", prg_addr[20:13], swap_ok ? 8'hFE : bank);
		drive_bus(16'hC000, 14'h0);
		byte_equal("prg_addr[20:13]", prg_addr[20:13], swap_ok ? bank : 8'hFE);
		drive_bus(16'hA000, 14'h0);
		byte_equal("prg_addr[20:13]", prg_addr[20:13], 8'h01);
	endtask

	task automatic prg_swap();
		prg_swap_variant(MAP_VRC24_23, 2'd1, 8'h15);
		prg_swap_variant(MAP_VRC24_25, 2'd1, 8'h2A);
		prg_swap_variant(MAP_VRC2_22, 2'd0, 8'h33);
		test_done("prg_swap");
	endtask

	task automatic chr_variant(input logic [7:0] map, input logic [1:0] sub);
		logic [8:0]  val [8];
		logic [31:0] rnd;
		logic [7:0]  exp;
		select_variant(map, sub, 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			val[i] = rnd[8:0];
			cpu_write(reg_cpu_addr(map, sub, 4'hB + 4'(i / 2), {i[0], 1'b0}), {4'h0, val[i][3:0]});
			cpu_write(reg_cpu_addr(map, sub, 4'hB + 4'(i / 2), {i[0], 1'b1}), {3'd0, val[i][8:4]});
		end
		for (int i = 0; i < 8; i++)
		begin
			exp = map == MAP_VRC2_22 ? val[i][8:1] : val[i][7:0]; // 22 drops bit 0
			drive_bus(16'h8000, {1'b0, 3'(i), 10'h155});
			word_equal("chr_addr", chr_addr, {exp, 10'h155});
		end
	endtask

	task automatic chr_banks_all();
		chr_variant(MAP_VRC4_21, 2'd1);
		chr_variant(MAP_VRC4_21, 2'd2);
		chr_variant(MAP_VRC4_21, 2'd0); // auto wiring
		chr_variant(MAP_VRC2_22, 2'd0);
		chr_variant(MAP_VRC24_23, 2'd1);
		chr_variant(MAP_VRC24_23, 2'd2);
		chr_variant(MAP_VRC24_23, 2'd0);
		chr_variant(MAP_VRC24_25, 2'd1);
		chr_variant(MAP_VRC24_25, 2'd2);
		chr_variant(MAP_VRC24_25, 2'd0);
		test_done("chr_banks");
	endtask

	task automatic vrc2_latch();
		select_variant(MAP_VRC2_22, 2'd0, 1'b1);
		cpu_write(16'h6000, 8'h01);
		drive_bus(16'h6000, 14'h0);
		bit_equal("map_cpu_oe", map_cpu_oe, 1'b1);
		byte_equal("map_cpu_dout", map_cpu_dout, 8'h61);
		drive_bus(16'h6E5A, 14'h0);
		byte_equal("map_cpu_dout", map_cpu_dout, {7'h37, 1'b1});
		cpu_write(16'h6000, 8'hFE);
		drive_bus(16'h6000, 14'h0);
		byte_equal("map_cpu_dout", map_cpu_dout, 8'h60);
		@(negedge m2);
		cfg_prg_ram_off = 1'b0;
		drive_bus(16'h6000, 14'h0);
		bit_equal("map_cpu_oe", map_cpu_oe, 1'b0); // prg ram owns $6000 now
		test_done("vrc2_latch");
	endtask

	task automatic irq_run(input logic [7:0] lat);
		int   n;
		int   exp_edges;
		logic rose;
		exp_edges = 256 - int'(lat);
		select_variant(MAP_VRC4_21, 2'd1, 1'b0);
		cpu_write(reg_cpu_addr(MAP_VRC4_21, 2'd1, 4'hF, 2'd0), {4'h0, lat[3:0]});
		cpu_write(reg_cpu_addr(MAP_VRC4_21, 2'd1, 4'hF, 2'd1), {4'h0, lat[7:4]});
		cpu_write(reg_cpu_addr(MAP_VRC4_21, 2'd1, 4'hF, 2'd2), 8'h06); // enable, cycle mode
		n = 0;
		do
		begin
			@(negedge m2);
			n++;
		end
		while (!irq && n < 300);
		checks++;
		assert (irq)
		else
		begin
			$display("irq did not rise within %0d cycles after the control write", n);
			errors++;
		end
		if (irq)
		begin
			assert (n == exp_edges)
			else
			begin
				$display("[FAIL] irq delay: got %h, expected %h", n, exp_edges);
				errors++;
			end
		end
		cpu_write(reg_cpu_addr(MAP_VRC4_21, 2'd1, 4'hF, 2'd3), 8'h00);
		bit_equal("irq", irq, 1'b0);
		rose = 1'b0;
		repeat (260)
		begin
			@(negedge m2);
			rose = rose | irq;
		end
		bit_equal("irq", rose, 1'b0); // ack-enable was 0, counter stopped
	endtask

	task automatic irq_masked_on_vrc2();
		logic rose;
		select_variant(MAP_VRC2_22, 2'd0, 1'b0);
		cpu_write(reg_cpu_addr(MAP_VRC2_22, 2'd0, 4'hF, 2'd0), 8'h0F);
		cpu_write(reg_cpu_addr(MAP_VRC2_22, 2'd0, 4'hF, 2'd1), 8'h0F);
		cpu_write(reg_cpu_addr(MAP_VRC2_22, 2'd0, 4'hF, 2'd2), 8'h06);
		rose = 1'b0;
		repeat (8)
		begin
			@(negedge m2);
			rose = rose | irq;
		end
		bit_equal("irq", rose, 1'b0); // counter overflows, vrc2 keeps irq low
		cpu_write(reg_cpu_addr(MAP_VRC2_22, 2'd0, 4'hF, 2'd3), 8'h00);
	endtask

	task automatic irq_cycle_mode();
		irq_run(8'hC8);
		irq_run(8'hFF);
		irq_masked_on_vrc2();
		test_done("irq_cycle_mode");
	endtask

	task automatic ss_read_check(input logic [7:0] slot, input logic [7:0] exp);
		@(negedge m2);
		ss_addr = slot;
		#5;
		byte_equal("ss_rdat", ss_rdat, exp);
	endtask

	task automatic save_state_roundtrip();
		logic [7:0]  d [19];
		logic [31:0] rnd;
		select_variant(MAP_VRC4_21, 2'd0, 1'b0);
		@(negedge m2);
		ss_act = 1'b1;
		for (int i = 0; i < 19; i++)
		begin
			rnd = $random(seed);
			d[i] = rnd[7:0];
			@(negedge m2);
			ss_addr = 8'(i);
			cpu_dat = d[i];
			ss_we = 1'b1;
		end
		@(negedge m2);
		ss_we = 1'b0;
		for (int i = 0; i < 19; i++)
		begin
			if (i < 8)
				ss_read_check(8'(i), d[i]);
			else if (i < 16)
				ss_read_check(8'(i), {7'd0, d[i][0]}); // chr bit 8 only
			else if (i == 18)
				ss_read_check(8'(i), {4'd0, d[i][3:0]});
			else
				ss_read_check(8'(i), d[i]);
		end
		ss_read_check(8'd127, MAP_VRC4_21);
		ss_read_check(8'd64, 8'hFF);
		@(negedge m2);
		ss_act = 1'b0;
		test_done("save_state");
	endtask

	initial
	begin
		m2 = 1'b0;
		map_rst = 1'b1;
		cpu_addr = 16'h0;
		cpu_dat = 8'h0;
		cpu_rw = 1'b1;
		ppu_addr = 14'h0;
		map_idx = MAP_VRC4_21;
		map_sub = 2'd0;
		cfg_prg_ram_off = 1'b0;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = 8'h0;
		seed = 62434;

		reset_defaults();
		prg_swap();
		chr_banks_all();
		vrc2_latch();
		irq_cycle_mode();
		save_state_roundtrip();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
hw/vrc_pkg.sv
hw/vrc_bus_if.sv
hw/vrc_reg_decode.sv
hw/vrc_bank_regs.sv
hw/vrc_irq.sv
hw/vrc_addr_map.sv
hw/vrc_mapper_top.sv
testbench/vrc_mapper_chk.sv
testbench/vrc_mapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mapper testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module vrc_mapper_tb -Mdir obj_dir -o vrc_sim -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/vrc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
